// ==== Makefile ====
TOP := tb_riscv_core

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 --top-module $(TOP) -f vlog.f

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Test completed successfully"

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -Wall --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// ==== common/core_pkg.sv ====
package core_pkg;

    typedef struct packed {
        logic                      valid;
        logic [isa_pkg::xlen-1:0]  pc;
        isa_pkg::instr_u           instr;
    } if_id_t;

    typedef struct packed {
        logic             reg_write;
        logic             mem_read;
        logic             mem_write;
        logic             alu_src;   // Immediate as second operand
        isa_pkg::alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        logic                     valid;
        ctrl_t                    ctrl;
        logic [isa_pkg::xlen-1:0] rs1_val;
        logic [isa_pkg::xlen-1:0] rs2_val;
        logic [isa_pkg::xlen-1:0] imm;
        isa_pkg::reg_addr_t       rd;
    } id_ex_t;

    typedef struct packed {
        logic                     valid;
        ctrl_t                    ctrl;
        logic [isa_pkg::xlen-1:0] alu_result;
        logic [isa_pkg::xlen-1:0] store_data;
        isa_pkg::reg_addr_t       rd;
    } ex_mem_t;

    // Register write, also seen at the top level
    typedef struct packed {
        logic                     valid;
        isa_pkg::reg_addr_t       rd;
        logic [isa_pkg::xlen-1:0] data;
    } wb_t;

    typedef struct packed {
        logic                     valid;
        logic [isa_pkg::xlen-1:0] addr; // Byte address from the ALU
        logic [isa_pkg::xlen-1:0] data;
    } store_t;

    typedef struct packed {
        logic                     we;
        logic [isa_pkg::xlen-1:0] addr; // Word index into instruction memory
        logic [isa_pkg::xlen-1:0] data;
    } imem_load_t;

endpackage

// ==== common/isa_pkg.sv ====
package isa_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_addr_t;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_t;

    localparam logic [2:0] F3_ADD_SUB = 3'b000; // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_SUB = 7'b0100000; // Selects SUB over ADD

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_t    opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_t     opcode;
    } instr_i_t;

    // Immediate split around rs2 and funct3
    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } instr_s_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
    } instr_u;

endpackage

// ==== design/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  core_pkg::if_id_t if_id,
    input  core_pkg::wb_t    wb,
    output core_pkg::id_ex_t id_ex
);

    isa_pkg::instr_u          instr;
    core_pkg::ctrl_t          ctrl;
    logic                     legal;
    logic [isa_pkg::xlen-1:0] imm;
    logic [isa_pkg::xlen-1:0] rs1_data;
    logic [isa_pkg::xlen-1:0] rs2_data;

    function automatic isa_pkg::alu_op_t alu_from_funct3(input logic [2:0] funct3,
                                                         input logic       sub);
        case (funct3)
            isa_pkg::F3_SLT: return isa_pkg::ALU_SLT;
            isa_pkg::F3_XOR: return isa_pkg::ALU_XOR;
            isa_pkg::F3_OR:  return isa_pkg::ALU_OR;
            isa_pkg::F3_AND: return isa_pkg::ALU_AND;
            default:         return sub ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
        endcase
    endfunction

    assign instr = if_id.instr;

    always_comb
    begin
        ctrl  = '0;
        legal = 1'b1;
        imm   = {{20{instr.i.imm[11]}}, instr.i.imm}; // I format unless a store
        case (instr.r.opcode)
            isa_pkg::OP:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_from_funct3(instr.r.funct3,
                                                 instr.r.funct7 == isa_pkg::F7_SUB);
                legal = instr.r.funct3 inside {isa_pkg::F3_ADD_SUB, isa_pkg::F3_SLT,
                                               isa_pkg::F3_XOR, isa_pkg::F3_OR,
                                               isa_pkg::F3_AND};
            end
            isa_pkg::OP_IMM:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_from_funct3(instr.i.funct3, 1'b0);
                legal = instr.i.funct3 inside {isa_pkg::F3_ADD_SUB, isa_pkg::F3_SLT,
                                               isa_pkg::F3_XOR, isa_pkg::F3_OR,
                                               isa_pkg::F3_AND};
            end
            isa_pkg::LOAD:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            isa_pkg::STORE:
            begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            end
            default: legal = 1'b0; // Retires as a bubble
        endcase
    end

    // rs1 and rs2 share positions across formats
    register_file i_register_file (
        .clk      (clk),
        .rs1      (instr.r.rs1),
        .rs2      (instr.r.rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // ID/EX register
    always_ff @(posedge clk)
    begin
        id_ex.ctrl    <= ctrl;
        id_ex.rs1_val <= rs1_data;
        id_ex.rs2_val <= rs2_data;
        id_ex.imm     <= imm;
        id_ex.rd      <= instr.r.rd;
        if (!rst_n)
            id_ex.valid <= 1'b0;
        else
            id_ex.valid <= if_id.valid & legal;
    end

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  core_pkg::id_ex_t  id_ex,
    output core_pkg::ex_mem_t ex_mem
);

    logic [isa_pkg::xlen-1:0] op_a;
    logic [isa_pkg::xlen-1:0] op_b;
    logic [isa_pkg::xlen-1:0] alu_result;

    assign op_a = id_ex.rs1_val;
    assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : id_ex.rs2_val;

    always_comb
    begin
        case (id_ex.ctrl.alu_op)
            isa_pkg::ALU_ADD: alu_result = op_a + op_b; // Also load/store address
            isa_pkg::ALU_SUB: alu_result = op_a - op_b;
            isa_pkg::ALU_AND: alu_result = op_a & op_b;
            isa_pkg::ALU_OR:  alu_result = op_a | op_b;
            isa_pkg::ALU_XOR: alu_result = op_a ^ op_b;
            isa_pkg::ALU_SLT:
            begin
                // Signed compare
                alu_result = {{(isa_pkg::xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            default:          alu_result = '0;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk)
    begin
        ex_mem.ctrl       <= id_ex.ctrl;
        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= id_ex.rs2_val;
        ex_mem.rd         <= id_ex.rd;
        if (!rst_n)
            ex_mem.valid <= 1'b0;
        else
            ex_mem.valid <= id_ex.valid;
    end

endmodule

// ==== design/fetch_stage.sv ====
`timescale 1ns/100ps

module fetch_stage #(
    parameter int imem_depth = 256
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 run,
    input  core_pkg::imem_load_t imem_load,
    output core_pkg::if_id_t     if_id
);

    localparam int imem_aw = $clog2(imem_depth);

    logic [isa_pkg::xlen-1:0] pc;
    logic [isa_pkg::xlen-1:0] imem [imem_depth];

    // Load port, one word per cycle
    always_ff @(posedge clk)
    begin
        if (imem_load.we)
            imem[imem_load.addr[imem_aw-1:0]] <= imem_load.data;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n || !run)
            pc <= '0; // Parked at the first word until run
        else
            pc <= pc + 32'd4;
    end

    // IF/ID register
    always_ff @(posedge clk)
    begin
        if_id.pc    <= pc;
        if_id.instr <= imem[pc[imem_aw+1:2]];
        if (!rst_n)
            if_id.valid <= 1'b0;
        else
            if_id.valid <= run; // Bubbles while halted
    end

endmodule

// ==== design/memory_stage.sv ====
`timescale 1ns/100ps

module memory_stage #(
    parameter int dmem_depth = 256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  core_pkg::ex_mem_t ex_mem,
    output core_pkg::wb_t     wb,
    output core_pkg::store_t  store
);

    localparam int dmem_aw = $clog2(dmem_depth);

    logic [isa_pkg::xlen-1:0] dmem [dmem_depth];
    logic [dmem_aw-1:0]       dmem_idx;
    logic                     store_en;
    logic [isa_pkg::xlen-1:0] load_data;

    // MEM/WB register
    logic                     mem_wb_valid;
    logic                     mem_wb_mem_read;
    isa_pkg::reg_addr_t       mem_wb_rd;
    logic [isa_pkg::xlen-1:0] mem_wb_alu;
    logic [isa_pkg::xlen-1:0] mem_wb_load;

    initial
    begin
        for (int i = 0; i < dmem_depth; i++)
            dmem[i] = '0; // Unwritten words read as zero
    end

    assign dmem_idx  = ex_mem.alu_result[dmem_aw+1:2]; // Byte address to word index
    assign store_en  = ex_mem.valid & ex_mem.ctrl.mem_write;
    assign load_data = dmem[dmem_idx];

    always_ff @(posedge clk)
    begin
        if (store_en)
            dmem[dmem_idx] <= ex_mem.store_data;
    end

    assign store.valid = store_en;
    assign store.addr  = ex_mem.alu_result;
    assign store.data  = ex_mem.store_data;

    always_ff @(posedge clk)
    begin
        mem_wb_mem_read <= ex_mem.ctrl.mem_read;
        mem_wb_rd       <= ex_mem.rd;
        mem_wb_alu      <= ex_mem.alu_result;
        mem_wb_load     <= load_data;
        if (!rst_n)
            mem_wb_valid <= 1'b0;
        else
            mem_wb_valid <= ex_mem.valid & ex_mem.ctrl.reg_write;
    end

    assign wb.valid = mem_wb_valid;
    assign wb.rd    = mem_wb_rd;
    assign wb.data  = mem_wb_mem_read ? mem_wb_load : mem_wb_alu;

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/100ps

module register_file (
    input  logic                     clk,
    input  isa_pkg::reg_addr_t       rs1,
    input  isa_pkg::reg_addr_t       rs2,
    input  core_pkg::wb_t            wb,
    output logic [isa_pkg::xlen-1:0] rs1_data,
    output logic [isa_pkg::xlen-1:0] rs2_data
);

    logic [isa_pkg::xlen-1:0] regs [32];

    // All registers power up as zero
    initial
    begin
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
    end

    // x0 reads zero, a write in flight wins over the bank
    function automatic logic [isa_pkg::xlen-1:0] read_reg(input isa_pkg::reg_addr_t addr);
        if (addr == '0)
            return '0;
        if (wb.valid && wb.rd == addr)
            return wb.data;
        return regs[addr];
    endfunction

    always_ff @(posedge clk)
    begin
        if (wb.valid && wb.rd != '0)
            regs[wb.rd] <= wb.data;
    end

    always_comb
    begin
        rs1_data = read_reg(rs1);
        rs2_data = read_reg(rs2);
    end

endmodule

// ==== design/riscv_core.sv ====
`timescale 1ns/100ps

module riscv_core #(
    parameter int imem_depth = 256,
    parameter int dmem_depth = 256
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 run,
    input  core_pkg::imem_load_t imem_load,
    output core_pkg::wb_t        wb,
    output core_pkg::store_t     store
);

    core_pkg::if_id_t  if_id;
    core_pkg::id_ex_t  id_ex;
    core_pkg::ex_mem_t ex_mem;

    fetch_stage #(
        .imem_depth (imem_depth)
    ) i_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .imem_load (imem_load),
        .if_id     (if_id)
    );

    // Writeback loops back into the register file here
    decode_stage i_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .if_id (if_id),
        .wb    (wb),
        .id_ex (id_ex)
    );

    execute_stage i_execute (
        .clk    (clk),
        .rst_n  (rst_n),
        .id_ex  (id_ex),
        .ex_mem (ex_mem)
    );

    memory_stage #(
        .dmem_depth (dmem_depth)
    ) i_memory (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_mem (ex_mem),
        .wb     (wb),
        .store  (store)
    );

endmodule

// ==== test/ref_model.svh ====
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// Register and memory state the core should hold, carried across tests
logic [31:0]      model_regs [32];
logic [31:0]      model_mem [dmem_depth];
logic [31:0]      prog [$];
core_pkg::wb_t    exp_wb [$];
core_pkg::store_t exp_st [$];

task automatic clear_model();
    for (int k = 0; k < 32; k++)
        model_regs[k] = '0;
    for (int k = 0; k < dmem_depth; k++)
        model_mem[k] = '0;
endtask

function automatic logic [dmem_aw-1:0] mem_index(input logic [31:0] addr);
    return dmem_aw'(addr >> 2); // Byte address to word, wraps at the memory size
endfunction

// RV32I results by funct3
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        isa_pkg::F3_ADD_SUB: return sub ? a - b : a + b;
        isa_pkg::F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        isa_pkg::F3_XOR:     return a ^ b;
        isa_pkg::F3_OR:      return a | b;
        default:             return a & b;
    endcase
endfunction

// One random program with its predicted events. An instruction reads the registers
// left by everything three or more slots ahead of it and none of the two just before
task automatic build_program(input int n, input int w_op, input int w_imm, input int w_load,
                             input int w_store, input int w_bad, input int reg_span);
    logic [2:0]         f3_list [5] = '{isa_pkg::F3_ADD_SUB, isa_pkg::F3_SLT,
                                        isa_pkg::F3_XOR, isa_pkg::F3_OR, isa_pkg::F3_AND};
    logic [6:0]         bad_ops [4] = '{7'b0110111, 7'b0010111, 7'b1101111, 7'b1100011};
    logic               lag_en [3];
    isa_pkg::reg_addr_t lag_rd [3];
    logic [31:0]        lag_data [3];
    isa_pkg::instr_u    ins;
    isa_pkg::reg_addr_t rd;
    isa_pkg::reg_addr_t rs1;
    isa_pkg::reg_addr_t rs2;
    logic [11:0]        imm;
    logic [31:0]        simm;
    logic [31:0]        addr;
    logic [2:0]         f3;
    logic [1:0]         slot;
    logic               sub;
    int                 pick;
    core_pkg::wb_t      wbe;
    core_pkg::store_t   ste;

    prog.delete();
    exp_wb.delete();
    exp_st.delete();
    for (int k = 0; k < 3; k++)
        lag_en[k] = 1'b0;
    // Three extra steps retire the writes still in flight at the end
    for (int i = 0; i < n + 3; i++)
    begin
        slot = 2'(i % 3);
        if (lag_en[slot] && lag_rd[slot] != '0)
            model_regs[lag_rd[slot]] = lag_data[slot]; // Write from three slots back
        lag_en[slot] = 1'b0;
        if (i < n)
        begin
            ins  = '0;
            rd   = 5'($urandom_range(0, reg_span - 1));
            rs1  = 5'($urandom_range(0, reg_span - 1));
            rs2  = 5'($urandom_range(0, reg_span - 1));
            imm  = 12'($urandom());
            f3   = f3_list[3'($urandom_range(0, 4))];
            pick = $urandom_range(0, w_op + w_imm + w_load + w_store + w_bad - 1);
            if (pick >= w_op + w_imm && $urandom_range(0, 3) != 0)
            begin
                rs1 = '0; // Low words off x0 so loads meet earlier stores
                imm = 12'(4 * $urandom_range(0, 15));
            end
            simm = {{20{imm[11]}}, imm};
            addr = model_regs[rs1] + simm;
            if (pick < w_op)
            begin
                sub   = (f3 == isa_pkg::F3_ADD_SUB) && ($urandom_range(0, 1) == 1);
                ins.r = '{sub ? isa_pkg::F7_SUB : 7'd0, rs2, rs1, f3, rd, isa_pkg::OP};
                lag_data[slot] = alu_ref(f3, sub, model_regs[rs1], model_regs[rs2]);
                lag_en[slot]   = 1'b1;
            end
            else if (pick < w_op + w_imm)
            begin
                if (f3 == isa_pkg::F3_SLT)
                    f3 = isa_pkg::F3_ADD_SUB; // SLTI is outside the mix
                ins.i = '{imm, rs1, f3, rd, isa_pkg::OP_IMM};
                lag_data[slot] = alu_ref(f3, 1'b0, model_regs[rs1], simm);
                lag_en[slot]   = 1'b1;
            end
            else if (pick < w_op + w_imm + w_load)
            begin
                ins.i = '{imm, rs1, 3'b010, rd, isa_pkg::LOAD};
                lag_data[slot] = model_mem[mem_index(addr)];
                lag_en[slot]   = 1'b1;
            end
            else if (pick < w_op + w_imm + w_load + w_store)
            begin
                ins.s = '{imm[11:5], rs2, rs1, 3'b010, imm[4:0], isa_pkg::STORE};
                ste   = '{1'b1, addr, model_regs[rs2]};
                model_mem[mem_index(addr)] = model_regs[rs2];
                exp_st.push_back(ste);
            end
            else
            begin
                // Unknown opcode retires as a bubble
                ins = isa_pkg::instr_u'($urandom());
                ins.r.opcode = isa_pkg::opcode_t'(bad_ops[2'($urandom_range(0, 3))]);
            end
            lag_rd[slot] = rd;
            if (lag_en[slot])
            begin
                wbe = '{1'b1, rd, lag_data[slot]};
                exp_wb.push_back(wbe);
            end
            prog.push_back(ins);
        end
    end
endtask

`endif

// ==== test/tb_riscv_core.sv ====
`timescale 1ns/100ps

module tb_riscv_core;

    localparam int imem_depth = 256;
    localparam int dmem_depth = 256;
    localparam int dmem_aw    = $clog2(dmem_depth);
    localparam int prog_len   = 40;
    localparam int num_tests  = 7;
    // Time to load, run and drain every test plus slack
    localparam int watchdog_ns = (num_tests * (2 * prog_len + 20) + 50) * 10;

    logic                 clk;
    logic                 rst_n;
    logic                 run;
    core_pkg::imem_load_t imem_load;
    core_pkg::wb_t        wb;
    core_pkg::store_t     store;

    core_pkg::wb_t    got_wb [$];
    core_pkg::store_t got_st [$];
    int               errors;
    int               test_errors;
    int               tests_run;

    `include "ref_model.svh"

    riscv_core #(
        .imem_depth (imem_depth),
        .dmem_depth (dmem_depth)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .imem_load (imem_load),
        .wb        (wb),
        .store     (store)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Retirement monitor, away from the active edge
    always @(negedge clk)
    begin
        if (rst_n === 1'b1 && wb.valid)
            got_wb.push_back(wb);
        if (rst_n === 1'b1 && store.valid)
            got_st.push_back(store);
    end

    initial
    begin
        #(watchdog_ns);
        $display("Watchdog expired before all tests finished");
        $display("Test failed");
        $finish;
    end

    task automatic finish_test(input string name);
        $display("%s: %0d wb, %0d stores, %0d errors", name, exp_wb.size(), exp_st.size(),
                 test_errors);
        errors += test_errors;
        tests_run++;
    endtask

    // In-order compare, then the queues start empty for the next test
    task automatic check_events(input string name);
        assert (got_wb.size() == exp_wb.size())
        else
        begin
            $display("mismatch %s wb count: expected %0d, actual %0d", name, exp_wb.size(),
                     got_wb.size());
            test_errors++;
        end
        for (int k = 0; k < exp_wb.size() && k < got_wb.size(); k++)
        begin
            assert (got_wb[k] == exp_wb[k])
            else
            begin
                $display("mismatch %s wb[%0d]: expected x%0d=%08h, actual x%0d=%08h", name, k,
                         exp_wb[k].rd, exp_wb[k].data, got_wb[k].rd, got_wb[k].data);
                test_errors++;
            end
        end
        assert (got_st.size() == exp_st.size())
        else
        begin
            $display("mismatch %s store count: expected %0d, actual %0d", name,
                     exp_st.size(), got_st.size());
            test_errors++;
        end
        for (int k = 0; k < exp_st.size() && k < got_st.size(); k++)
        begin
            assert (got_st[k] == exp_st[k])
            else
            begin
                $display("mismatch %s store[%0d]: expected [%08h]=%08h, actual [%08h]=%08h",
                         name, k, exp_st[k].addr, exp_st[k].data, got_st[k].addr,
                         got_st[k].data);
                test_errors++;
            end
        end
        got_wb.delete();
        got_st.delete();
    endtask

    task automatic check_idle(input string name);
        test_errors = 0;
        exp_wb.delete();
        exp_st.delete();
        repeat (20) @(posedge clk);
        assert (got_wb.size() == 0 && got_st.size() == 0)
        else
        begin
            $display("%s: core retired %0d writebacks and %0d stores with run low", name,
                     got_wb.size(), got_st.size());
            test_errors++;
        end
        got_wb.delete();
        got_st.delete();
        finish_test(name);
    endtask

    task automatic run_program(input string name, input int w_op, input int w_imm,
                               input int w_load, input int w_store, input int w_bad,
                               input int reg_span);
        test_errors = 0;
        build_program(prog_len, w_op, w_imm, w_load, w_store, w_bad, reg_span);
        for (int k = 0; k < prog_len; k++)
        begin
            @(posedge clk);
            imem_load <= '{we: 1'b1, addr: 32'(k), data: prog[k]};
        end
        @(posedge clk);
        imem_load.we <= 1'b0;
        assert (got_wb.size() == 0 && got_st.size() == 0)
        else
        begin
            $display("%s: core retired an instruction during the program load", name);
            test_errors++;
        end
        run <= 1'b1;
        repeat (prog_len) @(posedge clk);
        run <= 1'b0;
        repeat (8) @(posedge clk); // Last fetch reaches wb four cycles later
        check_events(name);
        finish_test(name);
    endtask

    initial
    begin
        void'($urandom(32'h9a826360));
        rst_n     = 1'b0;
        run       = 1'b0;
        imem_load = '0;
        errors    = 0;
        tests_run = 0;
        clear_model();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        check_idle("reset_idle");
        run_program("alu_reg_imm", 50, 50, 0, 0, 0, 32);
        run_program("alu_imm_heavy", 30, 70, 0, 0, 0, 16);
        run_program("store_stream", 20, 20, 0, 60, 0, 32);
        run_program("load_store", 15, 15, 35, 35, 0, 16);
        run_program("close_deps", 35, 35, 15, 15, 0, 4); // Few registers, many hazards
        run_program("unknown_opcode", 25, 25, 10, 10, 30, 8);
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+test
common/isa_pkg.sv
common/core_pkg.sv
design/register_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/riscv_core.sv
test/tb_riscv_core.sv
